// File: src/hdc_pkg.sv
package hdc_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------

    // one prng output word
    localparam int word_w = 32;

    typedef logic [word_w-1:0] word_t;

    // axi-lite address and data
    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // item memory address, also the item-count value (1024 entries)
    typedef logic [9:0] item_addr_t;

    // ------------------------------------------------------------
    // register map
    // ------------------------------------------------------------

    // mode register, bit 0 gen, bit 1 run
    localparam axil_addr_t reg_mode_off = 32'h0000_0000;

    // number of items minus one
    localparam axil_addr_t reg_count_off = 32'h0000_0004;

    // okay response for both b and r channels
    localparam logic [1:0] axil_resp_okay = 2'b00;

    // prng start value, must never be zero
    localparam word_t xorshift_seed = 32'h2463_534a;

    // axi-lite slave states
    typedef enum logic [2:0] {
        idle,
        aw_only,
        w_only,
        write_resp,
        read_fetch,
        read_resp
    } axil_state_t;

endpackage

// File: src/axil_regs.sv
`timescale 1ns/1ns

module axil_regs (
    input  logic                 AXIS_ACLK,
    input  logic                 S_AXI_ARESETN,

    // write address / data / response
    input  hdc_pkg::axil_addr_t  s_axi_awaddr,
    input  logic                 s_axi_awvalid,
    output logic                 s_axi_awready,
    input  hdc_pkg::axil_data_t  s_axi_wdata,
    input  logic [3:0]           s_axi_wstrb,
    input  logic                 s_axi_wvalid,
    output logic                 s_axi_wready,
    output logic [1:0]           s_axi_bresp,
    output logic                 s_axi_bvalid,
    input  logic                 s_axi_bready,

    // read address / data
    input  hdc_pkg::axil_addr_t  s_axi_araddr,
    input  logic                 s_axi_arvalid,
    output logic                 s_axi_arready,
    output hdc_pkg::axil_data_t  s_axi_rdata,
    output logic [1:0]           s_axi_rresp,
    output logic                 s_axi_rvalid,
    input  logic                 s_axi_rready,

    // accelerator control
    input  logic                 gen_done,
    output logic                 gen,
    output logic                 run,
    output hdc_pkg::item_addr_t  item_count
);

    hdc_pkg::axil_state_t state;

    // word address bits only, byte lane bits dropped
    logic [11:2]          wr_idx;
    logic [11:2]          rd_idx;
    hdc_pkg::axil_data_t  wr_data;

    logic                 aw_hs;
    logic                 w_hs;
    logic                 ar_hs;
    logic                 wr_fire;
    logic                 wr_en;
    logic [11:2]          cur_idx;
    hdc_pkg::axil_data_t  cur_data;
    hdc_pkg::axil_addr_t  wr_off;
    hdc_pkg::axil_addr_t  rd_off;

    // ------------------------------------------------------------
    // handshakes
    // ------------------------------------------------------------

    assign s_axi_awready = (state == hdc_pkg::idle) || (state == hdc_pkg::w_only);
    assign s_axi_wready  = (state == hdc_pkg::idle) || (state == hdc_pkg::aw_only);
    // writes go first when both arrive together
    assign s_axi_arready = (state == hdc_pkg::idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == hdc_pkg::write_resp);
    assign s_axi_rvalid  = (state == hdc_pkg::read_resp);
    assign s_axi_bresp   = hdc_pkg::axil_resp_okay;
    assign s_axi_rresp   = hdc_pkg::axil_resp_okay;

    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;
    assign ar_hs = s_axi_arvalid && s_axi_arready;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= hdc_pkg::idle;
        end else begin
            case (state)
                hdc_pkg::idle: begin
                    if (aw_hs && w_hs) begin
                        state <= hdc_pkg::write_resp;
                    end else if (aw_hs) begin
                        state <= hdc_pkg::aw_only;
                    end else if (w_hs) begin
                        state <= hdc_pkg::w_only;
                    end else if (ar_hs) begin
                        state <= hdc_pkg::read_fetch;
                    end
                end
                hdc_pkg::aw_only: begin
                    if (w_hs) begin
                        state <= hdc_pkg::write_resp;
                    end
                end
                hdc_pkg::w_only: begin
                    if (aw_hs) begin
                        state <= hdc_pkg::write_resp;
                    end
                end
                hdc_pkg::write_resp: begin
                    if (s_axi_bready) begin
                        state <= hdc_pkg::idle;
                    end
                end
                // one cycle to latch rdata
                hdc_pkg::read_fetch: begin
                    state <= hdc_pkg::read_resp;
                end
                hdc_pkg::read_resp: begin
                    if (s_axi_rready) begin
                        state <= hdc_pkg::idle;
                    end
                end
                default: begin
                    state <= hdc_pkg::idle;
                end
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge AXIS_ACLK) begin
        if (aw_hs) begin
            wr_idx <= s_axi_awaddr[11:2];
        end
        if (w_hs) begin
            wr_data <= s_axi_wdata;
        end
        if (ar_hs) begin
            rd_idx <= s_axi_araddr[11:2];
        end
    end

    // ------------------------------------------------------------
    // register write
    // ------------------------------------------------------------

    // whichever half arrives last comes straight from the bus
    assign cur_idx  = aw_hs ? s_axi_awaddr[11:2] : wr_idx;
    assign cur_data = w_hs ? s_axi_wdata : wr_data;
    assign wr_off   = {20'd0, cur_idx, 2'b00};
    assign rd_off   = {20'd0, rd_idx, 2'b00};

    // cycle in which write_resp is entered
    assign wr_fire = ((state == hdc_pkg::idle) && aw_hs && w_hs)
                  || ((state == hdc_pkg::aw_only) && w_hs)
                  || ((state == hdc_pkg::w_only) && aw_hs);
    assign wr_en   = wr_fire && (cur_idx[11:10] == 2'b00);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen        <= 1'b0;
            run        <= 1'b0;
            item_count <= '0;
        end else begin
            // a mode write beats the end-of-generation clear
            if (wr_en && (wr_off == hdc_pkg::reg_mode_off)) begin
                {run, gen} <= cur_data[1:0];
            end else if (gen_done) begin
                gen <= 1'b0;
            end
            if (wr_en && (wr_off == hdc_pkg::reg_count_off)) begin
                item_count <= hdc_pkg::item_addr_t'(cur_data);
            end
        end
    end

    // ------------------------------------------------------------
    // register read
    // ------------------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (state == hdc_pkg::read_fetch) begin
            if (rd_idx[11:10] != 2'b00) begin
                s_axi_rdata <= '0;
            end else if (rd_off == hdc_pkg::reg_mode_off) begin
                s_axi_rdata <= hdc_pkg::axil_data_t'({run, gen});
            end else if (rd_off == hdc_pkg::reg_count_off) begin
                s_axi_rdata <= hdc_pkg::axil_data_t'(item_count);
            end else begin
                s_axi_rdata <= '0;
            end
        end
    end

endmodule

// File: src/xorshift32.sv
`timescale 1ns/1ns

module xorshift32 (
    input  logic           AXIS_ACLK,
    input  logic           S_AXI_ARESETN,
    input  logic           gen,
    output hdc_pkg::word_t rand_word
);

    hdc_pkg::word_t state;

    // one xorshift32 step, 13 / 17 / 5
    function automatic hdc_pkg::word_t xs_step(input hdc_pkg::word_t s);
        hdc_pkg::word_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // output is the next state, so word 0 is already valid on the first gen cycle
    assign rand_word = xs_step(state);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            // parked on the seed between generation runs
            state <= hdc_pkg::xorshift_seed;
        end else begin
            state <= rand_word;
        end
    end

endmodule

// File: src/item_gen.sv
`timescale 1ns/1ns

module item_gen #(
    parameter int dim = 64
) (
    input  logic                AXIS_ACLK,
    input  logic                S_AXI_ARESETN,
    input  logic                gen,
    input  hdc_pkg::item_addr_t item_count,
    input  hdc_pkg::word_t      rand_word,
    output logic                item_we,
    output hdc_pkg::item_addr_t item_waddr,
    output logic [dim-1:0]      item_wdata,
    output logic                gen_done
);

    // prng words per hypervector
    localparam int words = dim / hdc_pkg::word_w;
    localparam int cnt_w = (words > 1) ? $clog2(words) : 1;

    logic [cnt_w-1:0] word_cnt;
    logic             word_last;
    // set after the last item, holds until gen drops
    logic             done;

    assign word_last = (word_cnt == cnt_w'(words - 1));

    // last write of the run
    assign gen_done = item_we && (item_waddr == item_count);

    // ------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            word_cnt   <= '0;
            item_we    <= 1'b0;
            item_waddr <= '0;
            done       <= 1'b0;
        end else begin
            if (!done) begin
                word_cnt <= word_last ? '0 : word_cnt + 1'b1;
            end
            // strobe one cycle after the last word of an item is shifted in
            item_we <= !done && !gen_done && word_last;
            if (item_we) begin
                item_waddr <= item_waddr + 1'b1;
            end
            if (gen_done) begin
                done <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // item assembly
    // ------------------------------------------------------------

    // new word enters at the top and moves down, so word 0 ends lowest
    always_ff @(posedge AXIS_ACLK) begin
        if (gen && !done) begin
            item_wdata <= dim'({rand_word, item_wdata} >> hdc_pkg::word_w);
        end
    end

endmodule

// File: src/item_lookup.sv
`timescale 1ns/1ns

module item_lookup #(
    parameter int dim = 64
) (
    input  logic                AXIS_ACLK,
    input  logic                S_AXI_ARESETN,
    input  logic                run,

    // write port from generation
    input  logic                item_we,
    input  hdc_pkg::item_addr_t item_waddr,
    input  logic [dim-1:0]      item_wdata,

    // item address stream in
    input  hdc_pkg::item_addr_t s_axis_tdata,
    input  logic                s_axis_tvalid,
    input  logic                s_axis_tlast,
    output logic                s_axis_tready,

    // hypervector stream out
    output logic [dim-1:0]      m_axis_tdata,
    output logic                m_axis_tvalid,
    output logic                m_axis_tlast,
    input  logic                m_axis_tready
);

    localparam int depth = 2 ** $bits(hdc_pkg::item_addr_t);

    logic [dim-1:0] item_mem [0:depth-1];
    logic           accept;

    // ------------------------------------------------------------
    // item memory
    // ------------------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (item_we) begin
            item_mem[item_waddr] <= item_wdata;
        end
    end

    // ------------------------------------------------------------
    // lookup stage, one item in flight
    // ------------------------------------------------------------

    // take a new address only if the output slot frees this cycle
    assign s_axis_tready = run && (!m_axis_tvalid || m_axis_tready);
    assign accept        = s_axis_tvalid && s_axis_tready;

    // read port lands directly in the output register
    always_ff @(posedge AXIS_ACLK) begin
        if (accept) begin
            m_axis_tdata <= item_mem[s_axis_tdata];
            m_axis_tlast <= s_axis_tlast;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            m_axis_tvalid <= 1'b0;
        end else if (accept) begin
            m_axis_tvalid <= 1'b1;
        end else if (m_axis_tready) begin
            // beat taken, nothing behind it
            m_axis_tvalid <= 1'b0;
        end
    end

endmodule

// File: src/hdc_top.sv
`timescale 1ns/1ns

module hdc_top #(
    parameter int dim = 64
) (
    input  logic                 AXIS_ACLK,
    input  logic                 S_AXI_ARESETN,

    // ------------------------------------------------------------
    // axi-lite slave
    // ------------------------------------------------------------
    input  hdc_pkg::axil_addr_t  s_axi_awaddr,
    input  logic                 s_axi_awvalid,
    output logic                 s_axi_awready,
    input  hdc_pkg::axil_data_t  s_axi_wdata,
    input  logic [3:0]           s_axi_wstrb,
    input  logic                 s_axi_wvalid,
    output logic                 s_axi_wready,
    output logic [1:0]           s_axi_bresp,
    output logic                 s_axi_bvalid,
    input  logic                 s_axi_bready,
    input  hdc_pkg::axil_addr_t  s_axi_araddr,
    input  logic                 s_axi_arvalid,
    output logic                 s_axi_arready,
    output hdc_pkg::axil_data_t  s_axi_rdata,
    output logic [1:0]           s_axi_rresp,
    output logic                 s_axi_rvalid,
    input  logic                 s_axi_rready,

    // ------------------------------------------------------------
    // axi-stream in / out
    // ------------------------------------------------------------
    input  hdc_pkg::item_addr_t  s_axis_tdata,
    input  logic                 s_axis_tvalid,
    input  logic                 s_axis_tlast,
    output logic                 s_axis_tready,
    output logic [dim-1:0]       m_axis_tdata,
    output logic [dim/8-1:0]     m_axis_tstrb,
    output logic                 m_axis_tvalid,
    output logic                 m_axis_tlast,
    input  logic                 m_axis_tready
);

    // mode levels and generation handshake
    logic                gen;
    logic                run;
    logic                gen_done;
    hdc_pkg::item_addr_t item_count;

    // generation write path
    hdc_pkg::word_t      rand_word;
    logic                item_we;
    hdc_pkg::item_addr_t item_waddr;
    logic [dim-1:0]      item_wdata;

    // every byte of a hypervector is valid
    assign m_axis_tstrb = '1;

    axil_regs u_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .gen_done      (gen_done),
        .gen           (gen),
        .run           (run),
        .item_count    (item_count)
    );

    xorshift32 u_prng (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .rand_word     (rand_word)
    );

    item_gen #(
        .dim (dim)
    ) u_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_count    (item_count),
        .rand_word     (rand_word),
        .item_we       (item_we),
        .item_waddr    (item_waddr),
        .item_wdata    (item_wdata),
        .gen_done      (gen_done)
    );

    item_lookup #(
        .dim (dim)
    ) u_lookup (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .run           (run),
        .item_we       (item_we),
        .item_waddr    (item_waddr),
        .item_wdata    (item_wdata),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

endmodule

// File: sim/hdc_props.sv
`timescale 1ns/1ns

module hdc_props #(
    parameter int dim = 64
) (
    input logic           AXIS_ACLK,
    input logic           S_AXI_ARESETN,
    input logic           run,
    input logic           s_axis_tready,
    input logic [dim-1:0] m_axis_tdata,
    input logic           m_axis_tvalid,
    input logic           m_axis_tlast,
    input logic           m_axis_tready,
    input logic           s_axi_bvalid,
    input logic           s_axi_rvalid
);

    // ------------------------------------------------------------
    // stream output
    // ------------------------------------------------------------

    // stalled beat stays put
    stall_hold: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)
    ) else $error("output beat changed while the consumer stalled");

    // no intake unless running
    ready_needs_run: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        s_axis_tready |-> run
    ) else $error("s_axis_tready high while run is low");

    // ------------------------------------------------------------
    // axi-lite responses
    // ------------------------------------------------------------
    one_response: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid)
    ) else $error("bvalid and rvalid high together");

endmodule

bind hdc_top hdc_props #(
    .dim (dim)
) u_props (
    .AXIS_ACLK     (AXIS_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .run           (run),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_rvalid  (s_axi_rvalid)
);

// File: sim/tb_hdc.sv
`timescale 1ns/1ns

module tb_hdc;

    localparam int dim       = 64;
    localparam int tbl_len   = 12;
    localparam int gen_count = 40;
    localparam int n_words   = 2 * (gen_count + 1);
    localparam int wd_cycles = tbl_len * 20 + 1024 * 2 * 4 + 2000;

    logic                AXIS_ACLK;
    logic                S_AXI_ARESETN;
    hdc_pkg::axil_addr_t s_axi_awaddr;
    logic                s_axi_awvalid;
    logic                s_axi_awready;
    hdc_pkg::axil_data_t s_axi_wdata;
    logic [3:0]          s_axi_wstrb;
    logic                s_axi_wvalid;
    logic                s_axi_wready;
    logic [1:0]          s_axi_bresp;
    logic                s_axi_bvalid;
    logic                s_axi_bready;
    hdc_pkg::axil_addr_t s_axi_araddr;
    logic                s_axi_arvalid;
    logic                s_axi_arready;
    hdc_pkg::axil_data_t s_axi_rdata;
    logic [1:0]          s_axi_rresp;
    logic                s_axi_rvalid;
    logic                s_axi_rready;
    hdc_pkg::item_addr_t s_axis_tdata;
    logic                s_axis_tvalid;
    logic                s_axis_tlast;
    logic                s_axis_tready;
    logic [dim-1:0]      m_axis_tdata;
    logic [dim/8-1:0]    m_axis_tstrb;
    logic                m_axis_tvalid;
    logic                m_axis_tlast;
    logic                m_axis_tready = 1'b0;

    // ------------------------------------------------------------
    // reference model words and lookup table
    // ------------------------------------------------------------
    logic [31:0]         model_words [n_words];
    string               tbl_name [tbl_len];
    hdc_pkg::item_addr_t tbl_addr [tbl_len];
    logic                tbl_last [tbl_len];
    logic [dim-1:0]      tbl_exp [tbl_len];

    integer seed;
    int     errors;
    int     checks;
    int     rx_count;
    bit     bp_on;
    bit     accept_seen;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    hdc_top #(
        .dim (dim)
    ) uut (
        .*
    );

    initial AXIS_ACLK = 1'b0;
    always #2 AXIS_ACLK = ~AXIS_ACLK;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    // xorshift32, shifts 13 / 17 / 5
    function automatic logic [31:0] next_xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    task automatic build_table();
        logic [31:0]         st;
        int                  a;
        hdc_pkg::item_addr_t addr_list [tbl_len];
        addr_list = '{10'd0, 10'd1, 10'd2, 10'd40, 10'd17, 10'd5,
                      10'd5, 10'd39, 10'd3, 10'd20, 10'd0, 10'd33};
        // words in generation order, starting one step past the seed
        st = 32'h2463_534a;
        for (int i = 0; i < n_words; i++) begin
            st = next_xorshift(st);
            model_words[i] = st;
        end
        for (int i = 0; i < tbl_len; i++) begin
            a = int'(addr_list[i]);
            tbl_addr[i] = addr_list[i];
            tbl_last[i] = (i % 4 == 3);
            // item k, word 2k low and 2k+1 high
            tbl_exp[i]  = {model_words[2 * a + 1], model_words[2 * a]};
            tbl_name[i] = $sformatf("lookup %0d addr %0d", i, a);
        end
    endtask

    // ------------------------------------------------------------
    // axi-lite master
    // ------------------------------------------------------------

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        bit aw_done;
        bit w_done;
        bit aw_hit;
        bit w_hit;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge AXIS_ACLK);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wvalid  <= 1'b1;
        while (!(aw_done && w_done)) begin
            // sampled mid-cycle, taken on the next edge
            @(negedge AXIS_ACLK);
            aw_hit = s_axi_awvalid && s_axi_awready;
            w_hit  = s_axi_wvalid && s_axi_wready;
            @(posedge AXIS_ACLK);
            if (aw_hit) begin
                s_axi_awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hit) begin
                s_axi_wvalid <= 1'b0;
                w_done = 1'b1;
            end
        end
        s_axi_bready <= 1'b1;
        @(negedge AXIS_ACLK);
        while (!s_axi_bvalid) @(negedge AXIS_ACLK);
        resp = s_axi_bresp;
        @(posedge AXIS_ACLK);
        s_axi_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        bit ar_hit;
        ar_hit = 1'b0;
        @(posedge AXIS_ACLK);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        while (!ar_hit) begin
            @(negedge AXIS_ACLK);
            ar_hit = s_axi_arvalid && s_axi_arready;
            @(posedge AXIS_ACLK);
        end
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b1;
        @(negedge AXIS_ACLK);
        while (!s_axi_rvalid) @(negedge AXIS_ACLK);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        @(posedge AXIS_ACLK);
        s_axi_rready <= 1'b0;
    endtask

    task automatic write_checked(input logic [31:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_value($sformatf("bresp at %h", addr), 64'(hdc_pkg::axil_resp_okay), 64'(resp));
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] expected,
                               input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_value(name, 64'(expected), 64'(data));
        check_value({name, " rresp"}, 64'(hdc_pkg::axil_resp_okay), 64'(resp));
    endtask

    // ------------------------------------------------------------
    // stream source, one beat per table entry
    // ------------------------------------------------------------
    task automatic send_table();
        bit hit;
        @(posedge AXIS_ACLK);
        for (int i = 0; i < tbl_len; i++) begin
            s_axis_tdata  <= tbl_addr[i];
            s_axis_tlast  <= tbl_last[i];
            s_axis_tvalid <= 1'b1;
            hit = 1'b0;
            while (!hit) begin
                @(negedge AXIS_ACLK);
                hit = s_axis_tvalid && s_axis_tready;
                @(posedge AXIS_ACLK);
            end
        end
        s_axis_tvalid <= 1'b0;
    endtask

    // consumer ready, random while back-pressure is on
    always @(posedge AXIS_ACLK) begin
        if (bp_on) begin
            m_axis_tready <= ($random(seed) & 1) != 0;
        end else begin
            m_axis_tready <= 1'b1;
        end
    end

    // output collector, beats compared in table order
    always @(negedge AXIS_ACLK) begin : collect
        int idx;
        if (accept_seen) begin
            expect_true(m_axis_tvalid, "m_axis_tvalid did not rise one cycle after acceptance");
        end
        accept_seen = s_axis_tvalid && s_axis_tready;
        if (m_axis_tvalid && m_axis_tready) begin
            idx = rx_count % tbl_len;
            check_value(tbl_name[idx], tbl_exp[idx], m_axis_tdata);
            check_value({tbl_name[idx], " tlast"}, 64'(tbl_last[idx]), 64'(m_axis_tlast));
            check_value({tbl_name[idx], " tstrb"}, 64'hff, 64'(m_axis_tstrb));
            rx_count++;
        end
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        seed          = 32'h5802_ecff;
        errors        = 0;
        checks        = 0;
        rx_count      = 0;
        bp_on         = 1'b0;
        accept_seen   = 1'b0;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 4'hf;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        build_table();

        repeat (16) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;

        // state right after reset
        @(negedge AXIS_ACLK);
        check_value("reset s_axis_tready", 64'd0, 64'(s_axis_tready));
        check_value("reset m_axis_tvalid", 64'd0, 64'(m_axis_tvalid));
        check_value("reset bvalid", 64'd0, 64'(s_axi_bvalid));
        check_value("reset rvalid", 64'd0, 64'(s_axi_rvalid));
        read_expect(32'h000, 32'd0, "reset mode");
        read_expect(32'h004, 32'd0, "reset count");

        // register access, aliases and unmapped offsets
        write_checked(32'h004, 32'd5);
        read_expect(32'h004, 32'd5, "count after write");
        write_checked(32'h008, 32'h3);
        write_checked(32'h404, 32'd7);
        write_checked(32'h400, 32'h3);
        write_checked(32'hc00, 32'h3);
        read_expect(32'h000, 32'd0, "mode after ignored writes");
        read_expect(32'h004, 32'd5, "count after ignored writes");
        read_expect(32'h008, 32'd0, "unmapped 0x008");
        read_expect(32'h404, 32'd0, "unmapped 0x404");
        read_expect(32'hffc, 32'd0, "unmapped 0xffc");

        // generation, gen clears itself at the end
        write_checked(32'h004, 32'(gen_count));
        write_checked(32'h000, 32'h1);
        read_expect(32'h000, 32'h1, "mode during generation");
        axil_read(32'h000, rd_data, rd_resp);
        while (rd_data[0] !== 1'b0) axil_read(32'h000, rd_data, rd_resp);
        check_value("mode after generation", 64'd0, 64'(rd_data));
        check_value("mode poll rresp", 64'(hdc_pkg::axil_resp_okay), 64'(rd_resp));

        // lookup, consumer always ready
        write_checked(32'h000, 32'h2);
        send_table();
        while (rx_count < tbl_len) @(posedge AXIS_ACLK);

        // same table under random back-pressure
        bp_on <= 1'b1;
        send_table();
        while (rx_count < 2 * tbl_len) @(posedge AXIS_ACLK);
        bp_on <= 1'b0;

        // run off, offered beats must stay parked
        write_checked(32'h000, 32'h0);
        @(posedge AXIS_ACLK);
        s_axis_tdata  <= 10'd3;
        s_axis_tvalid <= 1'b1;
        repeat (20) begin
            @(negedge AXIS_ACLK);
            expect_true(!s_axis_tready, "s_axis_tready high while run is off");
            expect_true(!m_axis_tvalid, "output beat appeared while run is off");
        end
        @(posedge AXIS_ACLK);
        s_axis_tvalid <= 1'b0;
        check_value("beats received", 64'(2 * tbl_len), 64'(rx_count));

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // hang guard sized from the table and a full-memory generation
    initial begin : watchdog
        repeat (wd_cycles) @(posedge AXIS_ACLK);
        $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

// File: tb.f
src/hdc_pkg.sv
src/axil_regs.sv
src/xorshift32.sv
src/item_gen.sv
src/item_lookup.sv
src/hdc_top.sv
sim/hdc_props.sv
sim/tb_hdc.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall -Wno-fatal
TOP        = tb_hdc
DUT_TOP    = hdc_top
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Something failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	    echo "simulation of $(DUT_TOP) failed, see $(LOG)"; \
	    exit 1; \
	fi
	@echo "simulation of $(DUT_TOP) passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
